// ==== compile.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/if_id_queue.sv
src/inst_decoder.sv
src/regfile.sv
src/id_stage.sv
src/id_subsystem_top.sv
verification/id_subsystem_assert.sv
verification/id_subsystem_tb.sv

// ==== verification/id_subsystem_tb.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module id_subsystem_tb;
  import isa_pkg::*;

  localparam int N_INST     = 200;
  localparam int MAX_WAIT   = 3;
  localparam int MAX_STALL  = 6;
  localparam int CLK_NS     = 8;
  // per instruction bound plus room for the register preload
  localparam int TIMEOUT_NS = N_INST * (MAX_WAIT + MAX_STALL + 4) * CLK_NS + 100 * CLK_NS;

  localparam logic [6:0] INTA_FUNCS [7] = '{`ADDQ_INST, `SUBQ_INST, `CMPEQ_INST,
    `CMPULT_INST, `CMPULE_INST, `CMPLT_INST, `CMPLE_INST};
  localparam logic [6:0] INTL_FUNCS [6] = '{`AND_INST, `BIC_INST, `BIS_INST,
    `ORNOT_INST, `XOR_INST, `EQV_INST};
  localparam logic [6:0] INTS_FUNCS [3] = '{`SRL_INST, `SLL_INST, `SRA_INST};
  localparam logic [5:0] MEM_OPS    [5] = '{`LDA_INST, `LDQ_INST, `LDQ_L_INST,
    `STQ_INST, `STQ_C_INST};

  // expected decode of one instruction
  typedef struct packed {
    opa_sel_e  opa;
    opb_sel_e  opb;
    alu_func_e alu;
    reg_idx_t  dest;
    logic [7:0] flags;  // rd, wr, ldl, stc, cond, uncond, halt, cpuid
    logic      illegal;
  } dec_t;

  logic       clock;
  logic       arst_n;
  logic       wb_cyc;
  logic       wb_stb;
  addr_t      wb_adr;
  inst_t      wb_dat;
  logic       wb_ack;
  logic       wr_en;
  reg_idx_t   wr_idx;
  word_t      wr_data;
  logic       id_ready;
  logic       id_valid;
  addr_t      id_npc;
  inst_t      id_inst;
  word_t      id_rega_value;
  word_t      id_regb_value;
  opa_sel_e   id_opa_select;
  opb_sel_e   id_opb_select;
  alu_func_e  id_alu_func;
  reg_idx_t   id_dest_reg_idx;
  logic id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem;
  logic id_cond_branch, id_uncond_branch;
  logic id_halt, id_cpuid, id_illegal, id_inst_valid;

  inst_t mem [256];
  word_t shadow [32];
  addr_t exp_adr;
  int    errors;
  int    n_checked;
  int    n_transfers;
  int    n_acks;

  id_subsystem_top DUT (.*);

  ////////////////////
  // checking helpers
  ////////////////////
  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // expected controls straight from the format rules
  function automatic dec_t decode_ref(inst_t inst);
    dec_t       d;
    logic [5:0] op;
    op     = inst[31:26];
    d      = '0;
    d.dest = `ID_ZERO_REG;
    if (op == `PAL_INST) begin
      if (inst[25:0] == `PAL_HALT) begin
        d.flags[1] = 1'b1;
      end else if (inst[25:0] == `PAL_WHAMI) begin
        d.flags[0] = 1'b1;
        d.dest     = inst[25:21];
      end else begin
        d.illegal = 1'b1;
      end
    end else if (op >= `INTA_GRP && op <= `FLTL_GRP) begin
      // operate format, fp groups fall to illegal
      d.opb  = inst[12] ? opb_is_alu_imm : opb_is_regb;
      d.dest = inst[4:0];
      case ({op, inst[11:5]})
        {`INTA_GRP, `ADDQ_INST}:   d.alu = alu_addq;
        {`INTA_GRP, `SUBQ_INST}:   d.alu = alu_subq;
        {`INTA_GRP, `CMPEQ_INST}:  d.alu = alu_cmpeq;
        {`INTA_GRP, `CMPULT_INST}: d.alu = alu_cmpult;
        {`INTA_GRP, `CMPULE_INST}: d.alu = alu_cmpule;
        {`INTA_GRP, `CMPLT_INST}:  d.alu = alu_cmplt;
        {`INTA_GRP, `CMPLE_INST}:  d.alu = alu_cmple;
        {`INTL_GRP, `AND_INST}:    d.alu = alu_and;
        {`INTL_GRP, `BIC_INST}:    d.alu = alu_bic;
        {`INTL_GRP, `BIS_INST}:    d.alu = alu_bis;
        {`INTL_GRP, `ORNOT_INST}:  d.alu = alu_ornot;
        {`INTL_GRP, `XOR_INST}:    d.alu = alu_xor;
        {`INTL_GRP, `EQV_INST}:    d.alu = alu_eqv;
        {`INTS_GRP, `SRL_INST}:    d.alu = alu_srl;
        {`INTS_GRP, `SLL_INST}:    d.alu = alu_sll;
        {`INTS_GRP, `SRA_INST}:    d.alu = alu_sra;
        {`INTM_GRP, `MULQ_INST}:   d.alu = alu_mulq;
        default:                   d.illegal = 1'b1;
      endcase
    end else if (op == `JSR_GRP) begin
      d.opa      = opa_is_not3;
      d.alu      = alu_and;
      d.dest     = inst[25:21];
      d.flags[2] = 1'b1;
    end else if ((op >= 6'h08 && op <= 6'h0f) || (op >= 6'h20 && op <= 6'h2f)) begin
      // memory format, address from displacement
      d.opa  = opa_is_mem_disp;
      d.dest = inst[25:21];
      if (op == `LDQ_INST) d.flags[7] = 1'b1;
      else if (op == `LDQ_L_INST) d.flags[7:5] = 3'b101;
      else if (op == `STQ_INST) begin
        d.flags[6] = 1'b1;
        d.dest     = `ID_ZERO_REG;
      end
      else if (op == `STQ_C_INST) d.flags[6:4] = 3'b101;
      else if (op != `LDA_INST) d.illegal = 1'b1;
    end else if (op >= `BR_INST) begin
      d.opa = opa_is_npc;
      d.opb = opb_is_br_disp;
      if (op == `BR_INST || op == `BSR_INST) begin
        d.dest     = inst[25:21];
        d.flags[2] = 1'b1;
      end else if (op <= `FBGT_INST) begin
        d.illegal = 1'b1;
      end else begin
        d.flags[3] = 1'b1;
      end
    end else begin
      d.illegal = 1'b1;
    end
    return d;
  endfunction

  // operand value seen by decode this cycle
  function automatic word_t reg_ref(reg_idx_t idx);
    word_t v;
    v = shadow[idx];
    if (wr_en && wr_idx == idx) v = wr_data;
    if (idx == `ID_ZERO_REG) v = '0;
    return v;
  endfunction

  function automatic inst_t make_inst();
    inst_t w;
    w = $urandom;
    case ($urandom_range(0, 12))
      0: w = {`PAL_INST, `PAL_HALT};
      1: w = {`PAL_INST, `PAL_WHAMI};
      2: w = {`INTA_GRP, w[25:12], INTA_FUNCS[$urandom_range(0, 6)], w[4:0]};
      3: w = {`INTL_GRP, w[25:12], INTL_FUNCS[$urandom_range(0, 5)], w[4:0]};
      4: w = {`INTS_GRP, w[25:12], INTS_FUNCS[$urandom_range(0, 2)], w[4:0]};
      5: w = {`INTM_GRP, w[25:12], `MULQ_INST, w[4:0]};
      6: w[31:26] = `ITFP_GRP + 6'($urandom_range(0, 3));
      7: w[31:26] = `JSR_GRP;
      8: w[31:26] = MEM_OPS[$urandom_range(0, 4)];
      9: w[31:26] = `BR_INST + 6'($urandom_range(0, 15));
      10: w[31:26] = ($urandom_range(0, 1) == 1) ? `MISC_GRP : `FTPI_GRP;
      11: ;
      default: w[31:26] = `PAL_INST;
    endcase
    return w;
  endfunction

  ////////////////////
  // clock, reset, end of run
  ////////////////////
  initial begin
    clock = 1'b0;
    forever #(CLK_NS / 2) clock = ~clock;
  end

  initial begin : main
    void'($urandom(52068));
    arst_n      = 1'b0;
    wb_dat      = '0;
    wb_ack      = 1'b0;
    wr_en       = 1'b0;
    wr_idx      = '0;
    wr_data     = '0;
    id_ready    = 1'b0;
    exp_adr     = `ID_RESET_PC;
    errors      = 0;
    n_checked   = 0;
    n_transfers = 0;
    n_acks      = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = make_inst();
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
    wait (n_checked == N_INST);
    @(negedge clock);
    $display("errors: %0d, records checked: %0d of %0d", errors, n_checked, N_INST);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: only %0d of %0d records arrived within %0d ns",
             n_checked, N_INST, TIMEOUT_NS);
    $display("errors: %0d, records checked: %0d of %0d", errors, n_checked, N_INST);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////
  // wishbone slave
  ////////////////////
  initial begin : wb_slave
    int waits_left;
    waits_left = -1;
    forever begin
      @(negedge clock);
      wb_ack = 1'b0;
      if (arst_n && wb_cyc) begin
        // queue holds two, fetch must be waiting
        if (n_acks - n_transfers >= 2) begin
          errors++;
          $display("fetch opened a bus cycle with two instructions waiting at %0t ns", $time);
        end
        if (waits_left < 0) waits_left = $urandom_range(0, MAX_WAIT);
        if (waits_left == 0) begin
          check("fetch address", wb_adr, exp_adr);
          wb_dat     = mem[wb_adr[9:2]];
          wb_ack     = 1'b1;
          exp_adr    = exp_adr + 64'd4;
          n_acks++;
          waits_left = -1;
        end else begin
          waits_left--;
        end
      end
    end
  end

  // write-back traffic and ready back-pressure
  initial begin : drive_inputs
    int stall_left;
    stall_left = 0;
    // preload so every operand read is known
    for (int i = 0; i < 32; i++) begin
      @(negedge clock);
      wr_en   = 1'b1;
      wr_idx  = reg_idx_t'(i);
      wr_data = {$urandom, $urandom};
    end
    forever begin
      @(negedge clock);
      wr_en   = ($urandom_range(0, 1) == 1);
      wr_data = {$urandom, $urandom};
      // aim at the head's ra now and then, for write-through
      if (id_valid && $urandom_range(0, 3) == 0) wr_idx = id_inst[25:21];
      else wr_idx = reg_idx_t'($urandom_range(0, 31));
      if (stall_left > 0) begin
        id_ready = 1'b0;
        stall_left--;
      end else if ($urandom_range(0, 3) == 0) begin
        id_ready   = 1'b0;
        stall_left = $urandom_range(0, MAX_STALL - 1);
      end else begin
        id_ready = 1'b1;
      end
    end
  end

  ////////////////////
  // record comparator
  ////////////////////
  initial begin : compare_records
    dec_t  exp;
    inst_t exp_inst;
    forever begin
      @(negedge clock);
      #2;
      if (!arst_n) begin
        check("wb_cyc in reset", wb_cyc, 1'b0);
        check("wb_stb in reset", wb_stb, 1'b0);
        check("id_valid in reset", id_valid, 1'b0);
      end else if (id_valid && id_ready) begin
        n_transfers++;
        if (n_checked < N_INST) begin
          exp_inst = mem[n_checked];
          exp      = decode_ref(exp_inst);
          check("id_inst", id_inst, exp_inst);
          check("id_npc", id_npc, `ID_RESET_PC + 64'(4 * (n_checked + 1)));
          check("id_opa_select", id_opa_select, exp.opa);
          check("id_opb_select", id_opb_select, exp.opb);
          check("id_alu_func", id_alu_func, exp.alu);
          check("id_dest_reg_idx", id_dest_reg_idx, exp.dest);
          check("flags rd/wr/ldl/stc/cond/uncond/halt/cpuid",
                {id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem,
                 id_cond_branch, id_uncond_branch, id_halt, id_cpuid}, exp.flags);
          check("id_illegal", id_illegal, exp.illegal);
          check("id_inst_valid", id_inst_valid, !exp.illegal);
          check("id_rega_value", id_rega_value, reg_ref(exp_inst[25:21]));
          check("id_regb_value", id_regb_value, reg_ref(exp_inst[20:16]));
          n_checked++;
        end
      end
      // write lands on the coming edge
      if (wr_en) shadow[wr_idx] = wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== verification/id_subsystem_assert.sv ====
`default_nettype none
`timescale 1ns/10ps

module id_subsystem_assert (
  input logic                      clock,
  input logic                      arst_n,
  // fetch bus
  input logic                      wb_cyc,
  input logic                      wb_stb,
  input isa_pkg::addr_t            wb_adr,
  input logic                      wb_ack,
  // decoded record
  input logic                      id_valid,
  input logic                      id_ready,
  input isa_pkg::addr_t            id_npc,
  input isa_pkg::inst_t            id_inst,
  input isa_pkg::alu_func_e        id_alu_func,
  input isa_pkg::reg_idx_t         id_dest_reg_idx
);

  ////////////////////
  // wishbone master
  ////////////////////
  // strobe and address held through wait states
  property stb_held_until_ack;
    @(posedge clock) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr));
  endproperty
  a_stb_held: assert property (stb_held_until_ack)
    else $error("wishbone strobe or address changed before ack");

  // cycle closes on the edge that sees ack
  property cycle_ends_on_ack;
    @(posedge clock) disable iff (!arst_n)
      (wb_cyc && wb_ack) |=> (!wb_cyc && !wb_stb);
  endproperty
  a_cycle_ends: assert property (cycle_ends_on_ack)
    else $error("wishbone cycle still open after ack");

  ////////////////////
  // output handshake
  ////////////////////
  // operand values may follow write-back but the rest must hold
  property record_held_while_stalled;
    @(posedge clock) disable iff (!arst_n)
      (id_valid && !id_ready) |=>
        (id_valid && $stable(id_inst) && $stable(id_npc)
         && $stable(id_alu_func) && $stable(id_dest_reg_idx));
  endproperty
  a_record_held: assert property (record_held_while_stalled)
    else $error("decoded record changed while stalled");

  // quiet outputs during reset
  a_reset_quiet: assert property (@(posedge clock) !arst_n |-> (!wb_cyc && !id_valid))
    else $error("bus cycle or record valid during reset");

endmodule

bind id_subsystem_top id_subsystem_assert u_assert (.*);

`default_nettype wire

// ==== src/id_subsystem_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module id_subsystem_top (
  input  logic               clock,
  input  logic               arst_n,
  // instruction fetch bus
  output logic               wb_cyc,
  output logic               wb_stb,
  output isa_pkg::addr_t     wb_adr,
  input  isa_pkg::inst_t     wb_dat,
  input  logic               wb_ack,
  // write-back port
  input  logic               wr_en,
  input  isa_pkg::reg_idx_t  wr_idx,
  input  isa_pkg::word_t     wr_data,
  // decoded record
  input  logic               id_ready,
  output logic               id_valid,
  output isa_pkg::addr_t     id_npc,
  output isa_pkg::inst_t     id_inst,
  output isa_pkg::word_t     id_rega_value,
  output isa_pkg::word_t     id_regb_value,
  output isa_pkg::opa_sel_e  id_opa_select,
  output isa_pkg::opb_sel_e  id_opb_select,
  output isa_pkg::alu_func_e id_alu_func,
  output isa_pkg::reg_idx_t  id_dest_reg_idx,
  output logic id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem,
  output logic id_cond_branch, id_uncond_branch,
  output logic id_halt, id_cpuid, id_illegal, id_inst_valid
);
  import isa_pkg::*;

  // fetch to queue
  logic  push;
  inst_t push_inst;
  addr_t push_npc;
  logic  full;

  // queue to decode
  logic  pop;
  logic  head_valid;
  inst_t head_inst;
  addr_t head_npc;

  ////////////////////
  // pipeline front
  ////////////////////
  // port names line up across the three blocks
  fetch_unit u_fetch (.*);

  if_id_queue u_queue (.*);

  id_stage u_id (.*);

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module id_stage (
  input  logic               clock,
  // queue head
  input  logic               head_valid,
  input  isa_pkg::inst_t     head_inst,
  input  isa_pkg::addr_t     head_npc,
  output logic               pop,
  // write-back port
  input  logic               wr_en,
  input  isa_pkg::reg_idx_t  wr_idx,
  input  isa_pkg::word_t     wr_data,
  // record to execute
  input  logic               id_ready,
  output logic               id_valid,
  output isa_pkg::addr_t     id_npc,
  output isa_pkg::inst_t     id_inst,
  output isa_pkg::word_t     id_rega_value,
  output isa_pkg::word_t     id_regb_value,
  output isa_pkg::opa_sel_e  id_opa_select,
  output isa_pkg::opb_sel_e  id_opb_select,
  output isa_pkg::alu_func_e id_alu_func,
  output isa_pkg::reg_idx_t  id_dest_reg_idx,
  output logic id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem,
  output logic id_cond_branch, id_uncond_branch,
  output logic id_halt, id_cpuid, id_illegal, id_inst_valid
);
  import isa_pkg::*;

  reg_idx_t  ra_idx;
  reg_idx_t  rb_idx;
  reg_idx_t  rc_idx;
  dest_sel_e dest_select;

  // register fields of the head instruction
  assign ra_idx = head_inst[25:21];
  assign rb_idx = head_inst[20:16];
  assign rc_idx = head_inst[4:0];

  // head of queue is the record, it stays put until popped
  assign id_valid = head_valid;
  assign id_npc   = head_npc;
  assign id_inst  = head_inst;
  assign pop      = head_valid & id_ready;

  regfile u_regfile (
    .clock   (clock),
    .rda_idx (ra_idx),
    .rdb_idx (rb_idx),
    .rda_out (id_rega_value),
    .rdb_out (id_regb_value),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  inst_decoder u_decoder (
    .inst          (head_inst),
    .inst_valid_in (head_valid),
    .opa_select    (id_opa_select),
    .opb_select    (id_opb_select),
    .dest_select   (dest_select),
    .alu_func      (id_alu_func),
    .rd_mem        (id_rd_mem),
    .wr_mem        (id_wr_mem),
    .ldl_mem       (id_ldl_mem),
    .stc_mem       (id_stc_mem),
    .cond_branch   (id_cond_branch),
    .uncond_branch (id_uncond_branch),
    .halt          (id_halt),
    .cpuid         (id_cpuid),
    .illegal       (id_illegal),
    .inst_valid    (id_inst_valid)
  );

  // destination select to index, zero reg means no write
  always_comb begin
    case (dest_select)
      dest_is_rega: id_dest_reg_idx = ra_idx;
      dest_is_regc: id_dest_reg_idx = rc_idx;
      default:      id_dest_reg_idx = `ID_ZERO_REG;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module regfile (
  input  logic              clock,
  input  isa_pkg::reg_idx_t rda_idx,
  input  isa_pkg::reg_idx_t rdb_idx,
  output isa_pkg::word_t    rda_out,
  output isa_pkg::word_t    rdb_out,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_idx,
  input  isa_pkg::word_t    wr_data
);
  import isa_pkg::*;

  word_t regs [32];

  // zero reg first, then bypass of a same-cycle write
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == `ID_ZERO_REG) begin
      return '0;
    end else if (wr_en && (wr_idx == idx)) begin
      return wr_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rda_out = read_port(rda_idx);
    rdb_out = read_port(rdb_idx);
  end

  // writes to r31 dropped
  always_ff @(posedge clock) begin
    if (wr_en && (wr_idx != `ID_ZERO_REG)) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module inst_decoder (
  input  isa_pkg::inst_t     inst,
  input  logic               inst_valid_in,
  output isa_pkg::opa_sel_e  opa_select,
  output isa_pkg::opb_sel_e  opb_select,
  output isa_pkg::dest_sel_e dest_select,
  output isa_pkg::alu_func_e alu_func,
  output logic rd_mem, wr_mem, ldl_mem, stc_mem,
  output logic cond_branch, uncond_branch,
  output logic halt, cpuid, illegal, inst_valid
);
  import isa_pkg::*;

  logic [5:0] opcode;
  logic [6:0] func;

  assign opcode = inst[31:26];
  assign func   = inst[11:5];

  // halt still counts, illegal does not
  assign inst_valid = inst_valid_in & ~illegal;

  always_comb begin
    // noop defaults, each format overrides what it needs
    opa_select    = opa_is_rega;
    opb_select    = opb_is_regb;
    dest_select   = dest_none;
    alu_func      = alu_addq;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    ldl_mem       = 1'b0;
    stc_mem       = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    cpuid         = 1'b0;
    illegal       = 1'b0;
    if (inst_valid_in) begin
      // top three opcode bits pick the format
      case ({inst[31:29], 3'b000})
        6'h00: begin
          if (opcode != `PAL_INST) begin
            illegal = 1'b1;
          end else if (inst[25:0] == `PAL_HALT) begin
            halt = 1'b1;
          end else if (inst[25:0] == `PAL_WHAMI) begin
            // cpu id lands in ra
            cpuid       = 1'b1;
            dest_select = dest_is_rega;
          end else begin
            illegal = 1'b1;
          end
        end

        ////////////////////
        // operate format
        ////////////////////
        6'h10: begin
          // literal form when bit 12 is set
          opb_select  = inst[12] ? opb_is_alu_imm : opb_is_regb;
          dest_select = dest_is_regc;
          case (opcode)
            `INTA_GRP: begin
              case (func)
                `ADDQ_INST:   alu_func = alu_addq;
                `SUBQ_INST:   alu_func = alu_subq;
                `CMPEQ_INST:  alu_func = alu_cmpeq;
                `CMPULT_INST: alu_func = alu_cmpult;
                `CMPULE_INST: alu_func = alu_cmpule;
                `CMPLT_INST:  alu_func = alu_cmplt;
                `CMPLE_INST:  alu_func = alu_cmple;
                default:      illegal  = 1'b1;
              endcase
            end
            `INTL_GRP: begin
              case (func)
                `AND_INST:   alu_func = alu_and;
                `BIC_INST:   alu_func = alu_bic;
                `BIS_INST:   alu_func = alu_bis;
                `ORNOT_INST: alu_func = alu_ornot;
                `XOR_INST:   alu_func = alu_xor;
                `EQV_INST:   alu_func = alu_eqv;
                default:     illegal  = 1'b1;
              endcase
            end
            `INTS_GRP: begin
              case (func)
                `SRL_INST: alu_func = alu_srl;
                `SLL_INST: alu_func = alu_sll;
                `SRA_INST: alu_func = alu_sra;
                default:   illegal  = 1'b1;
              endcase
            end
            `INTM_GRP: begin
              if (func == `MULQ_INST) alu_func = alu_mulq;
              else illegal = 1'b1;
            end
            // no floating point unit
            `ITFP_GRP, `FLTV_GRP, `FLTI_GRP, `FLTL_GRP: illegal = 1'b1;
            default: illegal = 1'b1;
          endcase
        end

        6'h18: begin
          case (opcode)
            `JSR_GRP: begin
              // jmp, jsr, ret, jsr_co all the same here
              // and with ~3 word-aligns the target
              opa_select    = opa_is_not3;
              alu_func      = alu_and;
              dest_select   = dest_is_rega;
              uncond_branch = 1'b1;
            end
            `MISC_GRP, `FTPI_GRP: illegal = 1'b1;
            default: illegal = 1'b1;
          endcase
        end

        ////////////////////
        // memory format
        ////////////////////
        6'h08, 6'h20, 6'h28: begin
          // address = rb + displacement
          opa_select  = opa_is_mem_disp;
          dest_select = dest_is_rega;
          case (opcode)
            `LDA_INST: ;
            `LDQ_INST: rd_mem = 1'b1;
            `LDQ_L_INST: begin
              rd_mem  = 1'b1;
              ldl_mem = 1'b1;
            end
            `STQ_INST: begin
              wr_mem      = 1'b1;
              dest_select = dest_none;
            end
            // store conditional returns its status in ra
            `STQ_C_INST: begin
              wr_mem  = 1'b1;
              stc_mem = 1'b1;
            end
            default: illegal = 1'b1;
          endcase
        end

        // branch format, target = npc + disp
        6'h30, 6'h38: begin
          opa_select = opa_is_npc;
          opb_select = opb_is_br_disp;
          case (opcode)
            `FBEQ_INST, `FBLT_INST, `FBLE_INST,
            `FBNE_INST, `FBGE_INST, `FBGT_INST: illegal = 1'b1;
            `BR_INST, `BSR_INST: begin
              // link address goes to ra
              dest_select   = dest_is_rega;
              uncond_branch = 1'b1;
            end
            default: cond_branch = 1'b1;
          endcase
        end

        default: illegal = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/if_id_queue.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module if_id_queue (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           push,
  input  isa_pkg::inst_t push_inst,
  input  isa_pkg::addr_t push_npc,
  output logic           full,
  input  logic           pop,
  output logic           head_valid,
  output isa_pkg::inst_t head_inst,
  output isa_pkg::addr_t head_npc
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // slot storage, payload only
  inst_t   slot_inst [`ID_QUEUE_DEPTH];
  addr_t   slot_npc  [`ID_QUEUE_DEPTH];
  qptr_t   wr_ptr;
  qptr_t   rd_ptr;
  qcount_t count;
  logic    do_push;
  logic    do_pop;

  assign full       = (count == qcount_t'(`ID_QUEUE_DEPTH));
  assign head_valid = (count != '0);
  assign head_inst  = slot_inst[rd_ptr];
  assign head_npc   = slot_npc[rd_ptr];

  // a pop on the same edge frees the slot for the push
  assign do_pop  = pop & head_valid;
  assign do_push = push & (~full | do_pop);

  always_ff @(posedge clock) begin
    if (do_push) begin
      slot_inst[wr_ptr] <= push_inst;
      slot_npc[wr_ptr]  <= push_npc;
    end
  end

  ////////////////////
  // pointers and count
  ////////////////////
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // one bit pointers wrap on their own
      if (do_push) begin
        wr_ptr <= wr_ptr + qptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + qptr_t'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + qcount_t'(1);
        2'b01:   count <= count - qcount_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "isa_macros.svh"

module fetch_unit (
  input  logic           clock,
  input  logic           arst_n,
  // wishbone classic master, read only
  output logic           wb_cyc,
  output logic           wb_stb,
  output isa_pkg::addr_t wb_adr,
  input  isa_pkg::inst_t wb_dat,
  input  logic           wb_ack,
  // queue side
  input  logic           full,
  output logic           push,
  output isa_pkg::inst_t push_inst,
  output isa_pkg::addr_t push_npc
);
  import isa_pkg::*;
  import pipe_pkg::*;

  fetch_state_e state;
  addr_t        pc;

  // cyc and stb always move together
  assign wb_cyc = (state == fetch_bus);
  assign wb_stb = wb_cyc;
  // address comes straight from the pc, so it holds through wait states
  assign wb_adr = pc;

  // capture on the ack edge, one pulse per bus cycle
  assign push      = wb_cyc & wb_ack;
  assign push_inst = wb_dat;
  assign push_npc  = pc + addr_t'(4);

  ////////////////////
  // bus cycle control
  ////////////////////
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= fetch_idle;
      pc    <= `ID_RESET_PC;
    end else begin
      case (state)
        fetch_idle: begin
          // only start when the queue has room for the result
          if (!full) begin
            state <= fetch_bus;
          end
        end
        fetch_bus: begin
          // cycle ends on the first edge that sees ack
          if (wb_ack) begin
            state <= fetch_idle;
            pc    <= push_npc;
          end
        end
        default: state <= fetch_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // fetch master states
  typedef enum logic {
    fetch_idle,
    fetch_bus
  } fetch_state_e;

  // slot pointer, wraps over two entries
  typedef logic [0:0] qptr_t;
  // occupancy 0..2
  typedef logic [1:0] qcount_t;

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // raw instruction word
  typedef logic [31:0] inst_t;
  // register value
  typedef logic [63:0] word_t;
  // pc or fetch address
  typedef logic [63:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  ////////////////////
  // datapath control encodings
  ////////////////////
  typedef enum logic [4:0] {
    alu_addq,
    alu_subq,
    alu_cmpult,
    alu_cmpule,
    alu_cmplt,
    alu_cmple,
    alu_cmpeq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_mulq
  } alu_func_e;

  // operand a source
  typedef enum logic [1:0] {
    opa_is_rega,
    opa_is_mem_disp,
    opa_is_npc,
    opa_is_not3
  } opa_sel_e;

  // operand b source
  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_alu_imm,
    opb_is_br_disp
  } opb_sel_e;

  typedef enum logic [1:0] {
    dest_none,
    dest_is_rega,
    dest_is_regc
  } dest_sel_e;

endpackage

`default_nettype wire

// ==== src/isa_macros.svh ====
`ifndef ISA_MACROS_SVH
`define ISA_MACROS_SVH

////////////////////
// pipeline constants
////////////////////
`define ID_RESET_PC     64'h0
// r31 reads zero, also the "no write" destination
`define ID_ZERO_REG     5'd31
`define ID_QUEUE_DEPTH  2

////////////////////
// opcode groups, inst[31:26]
////////////////////
`define PAL_INST    6'h00
`define LDA_INST    6'h08
`define INTA_GRP    6'h10
`define INTL_GRP    6'h11
`define INTS_GRP    6'h12
`define INTM_GRP    6'h13
`define ITFP_GRP    6'h14
`define FLTV_GRP    6'h15
`define FLTI_GRP    6'h16
`define FLTL_GRP    6'h17
`define MISC_GRP    6'h18
`define JSR_GRP     6'h1a
`define FTPI_GRP    6'h1c
`define LDQ_INST    6'h29
`define LDQ_L_INST  6'h2b
`define STQ_INST    6'h2d
`define STQ_C_INST  6'h2f
`define BR_INST     6'h30
`define FBEQ_INST   6'h31
`define FBLT_INST   6'h32
`define FBLE_INST   6'h33
`define BSR_INST    6'h34
`define FBNE_INST   6'h35
`define FBGE_INST   6'h36
`define FBGT_INST   6'h37

// operate format function codes, inst[11:5]
`define CMPULT_INST 7'h1d
`define ADDQ_INST   7'h20
`define SUBQ_INST   7'h29
`define CMPEQ_INST  7'h2d
`define CMPULE_INST 7'h3d
`define CMPLT_INST  7'h4d
`define CMPLE_INST  7'h6d
`define AND_INST    7'h00
`define BIC_INST    7'h08
`define BIS_INST    7'h20
`define ORNOT_INST  7'h28
`define XOR_INST    7'h40
`define EQV_INST    7'h48
`define SRL_INST    7'h34
`define SLL_INST    7'h39
`define SRA_INST    7'h3c
`define MULQ_INST   7'h20

// pal function field, inst[25:0]
`define PAL_HALT    26'h555
`define PAL_WHAMI   26'h03c

`endif
